// ==== rtl/cdc_fifo_pkg.sv ====
`default_nettype none

package cdc_fifo_pkg;

    // Every sample on the stream is a fixed 16-bit word
    localparam int SAMPLE_W = 16;

    typedef logic [SAMPLE_W-1:0] sample_t;

    // Pointers live in an 8-bit container so depths up to 128 fit with the wrap bit
    localparam int MAX_PTR_W = 8;

    // Bits above the pointer width of a given instance are kept at zero
    typedef logic [MAX_PTR_W-1:0] ptr_word_t;

    // Supported FIFO depths
    localparam int MIN_DEPTH = 2;
    localparam int MAX_DEPTH = 128;
    localparam int DEPTH_DEFAULT = 8;

    // One output beat as registered by the read side
    typedef struct packed {
        logic    valid;
        sample_t data;
    } sample_beat_t;

    // Binary to gray conversion
    // Zero upper bits stay zero, so a narrow pointer converts correctly in the wide container
    function automatic ptr_word_t bin_to_gray(input ptr_word_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // A depth must be a power of two inside the supported range
    function automatic bit depth_is_valid(input int depth);
        return (depth >= MIN_DEPTH) && (depth <= MAX_DEPTH) && ((depth & (depth - 1)) == 0);
    endfunction

endpackage

`default_nettype wire

// ==== rtl/gray_ptr_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync #(
    parameter int PTR_W = 4
) (
    input  wire                     clk_i,
    input  wire                     reset_ni,
    input  wire cdc_fifo_pkg::ptr_word_t ptr_gray,
    output cdc_fifo_pkg::ptr_word_t ptr_gray_sync
);

    // Only the low PTR_W bits carry the pointer
    localparam cdc_fifo_pkg::ptr_word_t PTR_MASK = cdc_fifo_pkg::ptr_word_t'((1 << PTR_W) - 1);

    // First stage may go metastable in silicon and is never used directly
    cdc_fifo_pkg::ptr_word_t meta_q;

    // The source pointer is gray coded, so at most one bit is in motion at any time
    // Whatever the first stage settles to is then either the old or the new pointer
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            meta_q        <= '0;
            ptr_gray_sync <= '0;
        end else begin
            meta_q        <= ptr_gray & PTR_MASK;
            ptr_gray_sync <= meta_q;
        end
    end

    // The pointer must fit in the shared container and still have a wrap bit
    ptr_width_a: assert property (
        @(posedge clk_i) (PTR_W >= 2) && (PTR_W <= cdc_fifo_pkg::MAX_PTR_W)
    ) else $error("gray_ptr_sync: PTR_W %0d out of range", PTR_W);

endmodule

`default_nettype wire

// ==== rtl/fifo_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_mem #(
    parameter int DEPTH = cdc_fifo_pkg::DEPTH_DEFAULT
) (
    input  wire                          clk_i,
    input  wire                          wr_en,
    input  wire cdc_fifo_pkg::ptr_word_t wr_addr,
    input  wire cdc_fifo_pkg::sample_t   wr_data,
    input  wire cdc_fifo_pkg::ptr_word_t rd_addr,
    output cdc_fifo_pkg::sample_t        rd_data
);

    localparam int ADDR_W = $clog2(DEPTH);

    // Storage array, one entry per FIFO slot
    cdc_fifo_pkg::sample_t mem_q [DEPTH];

    // Low address bits select the entry
    // The wrap bit of each pointer is dropped here
    logic [ADDR_W-1:0] wr_idx;
    logic [ADDR_W-1:0] rd_idx;

    assign wr_idx = wr_addr[ADDR_W-1:0];
    assign rd_idx = rd_addr[ADDR_W-1:0];

    // Writes happen in the write clock domain only
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_idx] <= wr_data;
        end
    end

    // The read port is asynchronous
    // The read controller registers the word in its own clock domain
    assign rd_data = mem_q[rd_idx];

    depth_legal_a: assert property (
        @(posedge clk_i) cdc_fifo_pkg::depth_is_valid(DEPTH)
    ) else $error("fifo_mem: DEPTH %0d is not a power of two in range", DEPTH);

endmodule

`default_nettype wire

// ==== rtl/fifo_write_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_write_ctrl #(
    parameter int DEPTH = cdc_fifo_pkg::DEPTH_DEFAULT
) (
    input  wire                          clk_i,
    input  wire                          reset_ni,
    input  wire cdc_fifo_pkg::sample_t   in_data,
    input  wire                          in_valid,
    input  wire cdc_fifo_pkg::ptr_word_t rd_ptr_gray_sync,
    output logic                         wr_en,
    output cdc_fifo_pkg::ptr_word_t      wr_addr,
    output cdc_fifo_pkg::sample_t        wr_data,
    output cdc_fifo_pkg::ptr_word_t      wr_ptr_gray,
    output logic                         overflow
);

    localparam int ADDR_W = $clog2(DEPTH);

    // One extra pointer bit tells a full FIFO apart from an empty one
    localparam int PTR_W = ADDR_W + 1;

    localparam cdc_fifo_pkg::ptr_word_t PTR_MASK  = cdc_fifo_pkg::ptr_word_t'((1 << PTR_W) - 1);
    localparam cdc_fifo_pkg::ptr_word_t ADDR_MASK = cdc_fifo_pkg::ptr_word_t'((1 << ADDR_W) - 1);

    // In gray code a pointer exactly DEPTH ahead differs in its top two bits only
    localparam cdc_fifo_pkg::ptr_word_t FULL_FLIP = cdc_fifo_pkg::ptr_word_t'(3) << (PTR_W - 2);

    cdc_fifo_pkg::ptr_word_t wr_ptr_bin;
    cdc_fifo_pkg::ptr_word_t wr_ptr_bin_next;
    logic                    full;
    logic                    push;

    // Full when the writer is a whole lap ahead of the last read pointer seen here
    // The read pointer seen here can only lag, so full may clear late but never early
    assign full = (wr_ptr_gray == (rd_ptr_gray_sync ^ FULL_FLIP));

    // A strobe is accepted only while there is room
    assign push = in_valid && !full;

    // Next binary pointer wraps inside PTR_W bits
    assign wr_ptr_bin_next = (wr_ptr_bin + cdc_fifo_pkg::ptr_word_t'(1)) & PTR_MASK;

    // Memory write port is driven straight from the accepted strobe
    assign wr_en   = push;
    assign wr_addr = wr_ptr_bin & ADDR_MASK;
    assign wr_data = in_data;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
            overflow    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_bin  <= wr_ptr_bin_next;
                // Registered gray copy is what crosses to the read side
                wr_ptr_gray <= cdc_fifo_pkg::bin_to_gray(wr_ptr_bin_next);
            end
            // A dropped sample is remembered until the next reset
            if (in_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    depth_legal_a: assert property (
        @(posedge clk_i) cdc_fifo_pkg::depth_is_valid(DEPTH)
    ) else $error("fifo_write_ctrl: DEPTH %0d is not a power of two in range", DEPTH);

    // A full FIFO must leave the write pointer where it is on the following edge
    no_advance_when_full_a: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        full |=> $stable(wr_ptr_gray)
    ) else $error("fifo_write_ctrl: write pointer advanced while full");

    // Overflow is sticky and only a reset may clear it
    overflow_sticky_a: assert property (
        @(posedge clk_i) (overflow && reset_ni) |=> overflow
    ) else $error("fifo_write_ctrl: overflow fell without reset");

endmodule

`default_nettype wire

// ==== rtl/fifo_read_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_read_ctrl #(
    parameter int DEPTH = cdc_fifo_pkg::DEPTH_DEFAULT
) (
    input  wire                          clk_i,
    input  wire                          reset_ni,
    input  wire cdc_fifo_pkg::ptr_word_t wr_ptr_gray_sync,
    output cdc_fifo_pkg::ptr_word_t      rd_addr,
    input  wire cdc_fifo_pkg::sample_t   rd_data,
    output cdc_fifo_pkg::ptr_word_t      rd_ptr_gray,
    output cdc_fifo_pkg::sample_beat_t   beat
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int PTR_W  = ADDR_W + 1;

    localparam cdc_fifo_pkg::ptr_word_t PTR_MASK  = cdc_fifo_pkg::ptr_word_t'((1 << PTR_W) - 1);
    localparam cdc_fifo_pkg::ptr_word_t ADDR_MASK = cdc_fifo_pkg::ptr_word_t'((1 << ADDR_W) - 1);

    // Gray to binary conversion for the synchronized write pointer
    function automatic cdc_fifo_pkg::ptr_word_t gray_to_bin(input cdc_fifo_pkg::ptr_word_t gray);
        cdc_fifo_pkg::ptr_word_t bin;
        bin[cdc_fifo_pkg::MAX_PTR_W-1] = gray[cdc_fifo_pkg::MAX_PTR_W-1];
        for (int i = cdc_fifo_pkg::MAX_PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    cdc_fifo_pkg::ptr_word_t rd_ptr_bin;
    cdc_fifo_pkg::ptr_word_t rd_ptr_bin_next;
    cdc_fifo_pkg::ptr_word_t wr_ptr_bin_sync;
    cdc_fifo_pkg::ptr_word_t fill;
    logic                    empty;

    // Empty when the reader has caught up with the last write pointer seen here
    // A late write pointer only delays the reader, it never lets it run ahead
    assign empty = (rd_ptr_gray == wr_ptr_gray_sync);

    assign rd_ptr_bin_next = (rd_ptr_bin + cdc_fifo_pkg::ptr_word_t'(1)) & PTR_MASK;

    // The memory is addressed by the current read slot
    assign rd_addr = rd_ptr_bin & ADDR_MASK;

    // Occupancy as seen by the read side, used only for checking
    assign wr_ptr_bin_sync = gray_to_bin(wr_ptr_gray_sync);
    assign fill            = (wr_ptr_bin_sync - rd_ptr_bin) & PTR_MASK;

    // One beat leaves on every cycle while data is available
    // With nothing to send valid drops and the last data is held
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
            beat        <= '0;
        end else if (!empty) begin
            beat.valid  <= 1'b1;
            beat.data   <= rd_data;
            rd_ptr_bin  <= rd_ptr_bin_next;
            rd_ptr_gray <= cdc_fifo_pkg::bin_to_gray(rd_ptr_bin_next);
        end else begin
            beat.valid <= 1'b0;
        end
    end

    depth_legal_a: assert property (
        @(posedge clk_i) cdc_fifo_pkg::depth_is_valid(DEPTH)
    ) else $error("fifo_read_ctrl: DEPTH %0d is not a power of two in range", DEPTH);

    // The reader may never overtake the writer
    // The distance between them can never exceed one full FIFO
    no_overtake_a: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        fill <= cdc_fifo_pkg::ptr_word_t'(DEPTH)
    ) else $error("fifo_read_ctrl: read pointer passed the write pointer");

endmodule

`default_nettype wire

// ==== rtl/cdc_sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_sample_fifo #(
    parameter int DEPTH = cdc_fifo_pkg::DEPTH_DEFAULT
) (
    input  wire                        clk_i,
    input  wire                        reset_ni,
    input  wire cdc_fifo_pkg::sample_t s_axis_in_tdata,
    input  wire                        s_axis_in_tvalid,
    input  wire                        out_clk_i,
    output cdc_fifo_pkg::sample_t      m_axis_out_tdata,
    output logic                       m_axis_out_tvalid,
    output logic                       overflow
);

    // Both synchronizers carry the full pointer including the wrap bit
    localparam int PTR_W = $clog2(DEPTH) + 1;

    // Write side to memory
    logic                    wr_en;
    cdc_fifo_pkg::ptr_word_t wr_addr;
    cdc_fifo_pkg::sample_t   wr_data;

    // Read side to memory
    cdc_fifo_pkg::ptr_word_t rd_addr;
    cdc_fifo_pkg::sample_t   rd_data;

    // Gray pointers and their copies in the opposite domain
    cdc_fifo_pkg::ptr_word_t wr_ptr_gray;
    cdc_fifo_pkg::ptr_word_t wr_ptr_gray_sync;
    cdc_fifo_pkg::ptr_word_t rd_ptr_gray;
    cdc_fifo_pkg::ptr_word_t rd_ptr_gray_sync;

    // Registered output beat of the read side
    cdc_fifo_pkg::sample_beat_t beat;

    // Input strobes in the clk_i domain
    fifo_write_ctrl #(
        .DEPTH(DEPTH)
    ) i_write_ctrl (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .in_data         (s_axis_in_tdata),
        .in_valid        (s_axis_in_tvalid),
        .rd_ptr_gray_sync(rd_ptr_gray_sync),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .wr_ptr_gray     (wr_ptr_gray),
        .overflow        (overflow)
    );

    fifo_mem #(
        .DEPTH(DEPTH)
    ) i_mem (
        .clk_i  (clk_i),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    // The read side runs entirely on out_clk_i
    fifo_read_ctrl #(
        .DEPTH(DEPTH)
    ) i_read_ctrl (
        .clk_i           (out_clk_i),
        .reset_ni        (reset_ni),
        .wr_ptr_gray_sync(wr_ptr_gray_sync),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .rd_ptr_gray     (rd_ptr_gray),
        .beat            (beat)
    );

    // Write pointer into the read domain
    gray_ptr_sync #(
        .PTR_W(PTR_W)
    ) i_wr_ptr_sync (
        .clk_i        (out_clk_i),
        .reset_ni     (reset_ni),
        .ptr_gray     (wr_ptr_gray),
        .ptr_gray_sync(wr_ptr_gray_sync)
    );

    // Read pointer back into the write domain for full detection
    gray_ptr_sync #(
        .PTR_W(PTR_W)
    ) i_rd_ptr_sync (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .ptr_gray     (rd_ptr_gray),
        .ptr_gray_sync(rd_ptr_gray_sync)
    );

    assign m_axis_out_tdata  = beat.data;
    assign m_axis_out_tvalid = beat.valid;

endmodule

`default_nettype wire

// ==== dv/cdc_sample_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_sample_fifo_tb;

    localparam int  DEPTH          = 8;
    localparam real CLK_HALF_NS    = 2.0;
    localparam real OUT_PHASE_NS   = 0.25;
    localparam real FAST_HALF_NS   = 1.5;
    localparam real SLOW_HALF_NS   = 20.0;
    localparam real DRIVE_DELAY_NS = 1.0;
    localparam int  RESET_CYCLES   = 3;
    localparam int  N_BURSTS       = 12;
    localparam int  MAX_BURST      = 8;
    localparam int  MAX_GAP        = 8;
    localparam int  OVF_STROBES    = 40;
    localparam int  IDLE_CYCLES    = 10;
    localparam int  QUIET_CYCLES   = 8;
    localparam bit [31:0] SEED     = 32'he77a_ea49;

    // Upper bound on strobes over both lossless phases
    localparam int  LOSSLESS_STROBES = 2 * N_BURSTS * MAX_BURST;

    // Each strobe gets 20 reader periods at the rate it runs under, plus fixed slack
    localparam real WATCHDOG_NS = LOSSLESS_STROBES * 20 * (2.0 * FAST_HALF_NS)
                                + OVF_STROBES * 20 * (2.0 * SLOW_HALF_NS) + 1000.0;

    logic                  clk_i;
    logic                  reset_ni;
    logic                  out_clk_i;
    cdc_fifo_pkg::sample_t s_axis_in_tdata;
    logic                  s_axis_in_tvalid;
    cdc_fifo_pkg::sample_t m_axis_out_tdata;
    logic                  m_axis_out_tvalid;
    logic                  overflow;

    // Reader half-period, starting with a quarter-ns phase step
    // All reader edges then sit off the integer grid that stimulus changes on
    real out_half = OUT_PHASE_NS;

    // Samples expected in order while nothing can be dropped
    cdc_fifo_pkg::sample_t ref_q[$];
    // Samples delivered during the overflow burst
    cdc_fifo_pkg::sample_t got_q[$];
    cdc_fifo_pkg::sample_t next_sample;
    cdc_fifo_pkg::sample_t burst_first;
    cdc_fifo_pkg::sample_t expected;
    logic                  lossy_mode;
    logic                  overflow_allowed;
    logic                  overflow_was_high;

    cdc_sample_fifo #(
        .DEPTH(DEPTH)
    ) i_dut (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .s_axis_in_tdata  (s_axis_in_tdata),
        .s_axis_in_tvalid (s_axis_in_tvalid),
        .out_clk_i        (out_clk_i),
        .m_axis_out_tdata (m_axis_out_tdata),
        .m_axis_out_tvalid(m_axis_out_tvalid),
        .overflow         (overflow)
    );

    always #(CLK_HALF_NS) clk_i = ~clk_i;

    // The reader clock period can be changed on the fly
    always #(out_half) out_clk_i = ~out_clk_i;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // One write-side cycle, with or without a strobe
    task automatic drive_cycle(input logic valid, input logic track);
        @(posedge clk_i);
        #(DRIVE_DELAY_NS);
        s_axis_in_tvalid = valid;
        if (valid) begin
            s_axis_in_tdata = next_sample;
            // Only the lossless phases know each strobe must come out
            if (track) begin
                ref_q.push_back(next_sample);
            end
            next_sample = next_sample + 16'd1;
        end
    endtask

    task automatic check_reset_outputs(input string when_txt);
        assert (m_axis_out_tvalid === 1'b0) else stop_on_error($sformatf(
            "** Error: m_axis_out_tvalid expected 0x0, got 0x%0h %s",
            m_axis_out_tvalid, when_txt));
        assert (overflow === 1'b0) else stop_on_error($sformatf(
            "** Error: overflow expected 0x0, got 0x%0h %s", overflow, when_txt));
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        #(DRIVE_DELAY_NS);
        reset_ni         = 1'b0;
        s_axis_in_tvalid = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY_NS);
        check_reset_outputs("during reset");
        ref_q.delete();
        got_q.delete();
        reset_ni = 1'b1;
        @(posedge clk_i);
        #(DRIVE_DELAY_NS);
        check_reset_outputs("after reset");
    endtask

    // Waits for every tracked sample to come out, then watches the idle output
    task automatic check_idle_after_drain();
        while (ref_q.size() != 0) begin
            @(negedge out_clk_i);
        end
        repeat (IDLE_CYCLES) begin
            @(negedge out_clk_i);
            assert (m_axis_out_tvalid === 1'b0)
                else stop_on_error("Output beat appeared while the FIFO was drained and idle");
        end
    endtask

    task automatic run_lossless_bursts();
        int burst_len;
        int gap;
        lossy_mode       = 1'b0;
        overflow_allowed = 1'b0;
        for (int b = 0; b < N_BURSTS; b++) begin
            burst_len = 1 + int'($urandom % MAX_BURST);
            gap       = 1 + int'($urandom % MAX_GAP);
            repeat (burst_len) drive_cycle(1'b1, 1'b1);
            repeat (gap) drive_cycle(1'b0, 1'b0);
            // Some bursts overlap in the FIFO, others drain fully first
            if ((($urandom % 3) == 0) || (b == N_BURSTS - 1)) begin
                check_idle_after_drain();
            end
        end
    endtask

    task automatic run_overflow_burst();
        int quiet;
        out_half = SLOW_HALF_NS;
        repeat (2) @(posedge out_clk_i);
        lossy_mode       = 1'b1;
        overflow_allowed = 1'b1;
        burst_first      = next_sample;
        repeat (OVF_STROBES) drive_cycle(1'b1, 1'b0);
        drive_cycle(1'b0, 1'b0);
        assert (overflow === 1'b1) else stop_on_error($sformatf(
            "** Error: overflow expected 0x1, got 0x%0h", overflow));
        // The FIFO starts empty, so the head of the burst always arrives
        while (got_q.size() < DEPTH) begin
            @(negedge out_clk_i);
        end
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge out_clk_i);
            quiet = (m_axis_out_tvalid === 1'b1) ? 0 : quiet + 1;
        end
        assert (got_q.size() < OVF_STROBES) else stop_on_error($sformatf(
            "** Error: delivered count expected below 0x%0h, got 0x%0h",
            OVF_STROBES, got_q.size()));
        for (int i = 0; i < DEPTH; i++) begin
            assert (int'(got_q[i]) == int'(burst_first) + i) else stop_on_error($sformatf(
                "** Error: m_axis_out_tdata expected 0x%04h, got 0x%04h",
                int'(burst_first) + i, got_q[i]));
        end
        // The next reset must be seen by a fast reader clock
        out_half = FAST_HALF_NS;
        repeat (2) @(posedge out_clk_i);
    endtask

    // Output checker, sampling halfway between reader edges
    always @(negedge out_clk_i) begin
        if ((reset_ni === 1'b1) && (m_axis_out_tvalid === 1'b1)) begin
            if (!lossy_mode) begin
                assert (ref_q.size() > 0)
                    else stop_on_error("Output beat arrived with no sample outstanding");
                expected = ref_q.pop_front();
                assert (m_axis_out_tdata === expected) else stop_on_error($sformatf(
                    "** Error: m_axis_out_tdata expected 0x%04h, got 0x%04h",
                    expected, m_axis_out_tdata));
            end else begin
                // Drops are allowed here, but only samples of this burst in rising order
                assert ((int'(m_axis_out_tdata) >= int'(burst_first)) &&
                        (int'(m_axis_out_tdata) < int'(burst_first) + OVF_STROBES))
                    else stop_on_error($sformatf(
                        "** Error: m_axis_out_tdata 0x%04h outside sent range 0x%04h+",
                        m_axis_out_tdata, burst_first));
                if (got_q.size() > 0) begin
                    assert (m_axis_out_tdata > got_q[$]) else stop_on_error($sformatf(
                        "** Error: m_axis_out_tdata expected above 0x%04h, got 0x%04h",
                        got_q[$], m_axis_out_tdata));
                end
                got_q.push_back(m_axis_out_tdata);
            end
        end
    end

    // Overflow checker on the write clock
    always @(negedge clk_i) begin
        if (reset_ni !== 1'b1) begin
            overflow_was_high = 1'b0;
        end else begin
            if (!overflow_allowed) begin
                assert (overflow === 1'b0) else stop_on_error($sformatf(
                    "** Error: overflow expected 0x0, got 0x%0h", overflow));
            end
            if (overflow_was_high) begin
                assert (overflow === 1'b1)
                    else stop_on_error("Overflow fell while reset was inactive");
            end
            overflow_was_high = (overflow === 1'b1);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error($sformatf("Run timed out after %0.0f ns without finishing",
            WATCHDOG_NS));
    end

    initial begin
        clk_i             = 1'b0;
        out_clk_i         = 1'b0;
        reset_ni          = 1'b0;
        s_axis_in_tdata   = '0;
        s_axis_in_tvalid  = 1'b0;
        next_sample       = '0;
        burst_first       = '0;
        expected          = '0;
        lossy_mode        = 1'b0;
        overflow_allowed  = 1'b0;
        overflow_was_high = 1'b0;
        void'($urandom(SEED));
        // First reader edge already took the phase step, switch to the fast rate
        #0.1;
        out_half = FAST_HALF_NS;

        apply_reset();
        run_lossless_bursts();
        run_overflow_burst();
        // Reset must clear overflow, then the lossless traffic runs again
        apply_reset();
        run_lossless_bursts();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cdc_sample_fifo.f ====
rtl/cdc_fifo_pkg.sv
rtl/gray_ptr_sync.sv
rtl/fifo_mem.sv
rtl/fifo_write_ctrl.sv
rtl/fifo_read_ctrl.sv
rtl/cdc_sample_fifo.sv
dv/cdc_sample_fifo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cdc_sample_fifo_tb \
    -f cdc_sample_fifo.f

# The verdict comes from the log, so a fatal stop must not end the script here
./obj_dir/Vcdc_sample_fifo_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Test completed successfully" "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
